/* sources.f */
verilog/mul_types_pkg.sv
verilog/cla_pkg.sv
verilog/cpa_if.sv
verilog/pp_decode.sv
verilog/dadda_reduce.sv
verilog/cpa_result.sv
verilog/dadda_mult_top.sv
verif/tb_clock.sv
verif/tb_dadda_mult.sv

/* Bender.yml */
package:
  name: dadda_mult

sources:
  # RTL, packages first
  - files:
      - verilog/mul_types_pkg.sv
      - verilog/cla_pkg.sv
      - verilog/cpa_if.sv
      - verilog/pp_decode.sv
      - verilog/dadda_reduce.sv
      - verilog/cpa_result.sv
      - verilog/dadda_mult_top.sv

  # Verification
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_dadda_mult.sv

/* verif/tb_dadda_mult.sv */
`timescale 1ns/1ps

module tb_dadda_mult #(
    parameter int cpa_block_width = 4
);
    import mul_types_pkg::*;

    localparam int drive_delay = 10;
    localparam int num_vec     = 16;
    localparam int num_post    = 4;    // Strobes after the mid-run reset
    localparam int num_pre     = 2;    // Strobes discarded by the reset
    localparam int num_random  = 200;
    localparam int num_strobes = 2 * num_vec + num_pre + num_post + num_random;
    localparam int max_cycles  = 4 * num_strobes + 20;
    localparam int drain_limit = 8;    // Idle cycles allowed for the last results

    // Columns are {a, b, expected product}
    localparam logic [31:0] vec_table [num_vec] = '{
        32'h00_00_0000,
        32'h00_ff_0000,
        32'hff_00_0000,
        32'h01_a7_00a7,
        32'h5c_01_005c,
        32'hff_ff_fe01,
        32'h80_80_4000,
        32'h01_80_0080,
        32'h40_02_0080,
        32'h10_08_0080,
        32'haa_55_3872,
        32'h55_55_1c39,
        32'haa_aa_70e4,
        32'hff_01_00ff,
        32'h0f_f0_0e10,
        32'hff_80_7f80
    };

    logic     clk;
    logic     por_n;
    logic     soft_rst_n;
    logic     rst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    product_t product;

    product_t    exp_q [$];
    logic [2:0]  occ = '0;     // Expected valid flags of the three stages
    logic        mon_on;
    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          product_errors = 0;
    int          valid_errors = 0;
    int          other_errors = 0;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (por_n)
    );

    assign rst_n = por_n & soft_rst_n;

    dadda_mult_top #(
        .cpa_block_width (cpa_block_width)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_operand(output operand_t val);
        val = '0;
        for (int k = 0; k < OPERAND_WIDTH; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[OPERAND_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_product(input product_t actual, input product_t expected);
        if (actual !== expected) begin
            $display("FAILED product: expected %h, got %h at %0t", expected, actual, $time);
            product_errors++;
        end
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED out_valid: expected %h, got %h at %0t", expected, actual, $time);
            valid_errors++;
        end
    endtask

    task automatic drive_cycle(input logic valid, input operand_t op_a, input operand_t op_b,
                               input product_t expected);
        @(posedge clk);
        #(drive_delay);
        in_valid = valid;
        a        = op_a;
        b        = op_b;
        if (valid) begin
            exp_q.push_back(expected);
        end
    endtask

    task automatic apply_entry(input int i);
        drive_cycle(1'b1, vec_table[i][31:24], vec_table[i][23:16], vec_table[i][15:0]);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, '0);
    endtask

    // Runs idle cycles until every expected result has come out or the limit is hit
    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < drain_limit) begin
            drive_cycle(1'b0, '0, '0, '0);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out by %0t", exp_q.size(), $time);
            other_errors++;
            exp_q.delete();
        end
        idle(3);
    endtask

    task automatic pulse_reset(input int n);
        repeat (n) begin
            @(posedge clk);
            #(drive_delay);
            soft_rst_n = 1'b0;
            in_valid   = 1'b0;
        end
        @(posedge clk);
        #(drive_delay);
        soft_rst_n = 1'b1;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (mon_on) begin
            check_valid(out_valid, occ[2]);
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Result %h came out with no operation pending at %0t",
                             product, $time);
                    other_errors++;
                end else begin
                    check_product(product, exp_q.pop_front());
                end
            end
        end
        // Mirrors what the next rising edge does to the pipeline
        if (rst_n !== 1'b1) begin
            occ = '0;
            exp_q.delete();
        end else begin
            occ = {occ[1:0], in_valid};
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        operand_t ra;
        operand_t rb;
        in_valid   = 1'b0;
        a          = '0;
        b          = '0;
        soft_rst_n = 1'b1;
        mon_on     = 1'b0;
        lfsr_state = 32'h5f02;
        @(posedge clk);
        mon_on = 1'b1;
        wait (por_n === 1'b1);

        // Corner operands on consecutive cycles
        for (int i = 0; i < num_vec; i++) begin
            apply_entry(i);
        end
        drain();

        // Same table with idle gaps of one to three cycles
        for (int i = 0; i < num_vec; i++) begin
            apply_entry(i);
            idle(1 + i % 3);
        end
        drain();

        // Strobes in flight are lost to the reset
        apply_entry(5);
        apply_entry(6);
        pulse_reset(2);
        idle(2);
        for (int i = 0; i < num_post; i++) begin
            apply_entry(10 + i);
        end
        drain();

        for (int i = 0; i < num_random; i++) begin
            next_operand(ra);
            next_operand(rb);
            drive_cycle(1'b1, ra, rb, product_t'(int'(ra) * int'(rb)));
        end
        drain();

        $display("Errors: product %0d, out_valid %0d, other %0d",
                 product_errors, valid_errors, other_errors);
        if (product_errors + valid_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period = 50,     // ns
    parameter int hold_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Released just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (hold_cycles) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

/* verilog/dadda_mult_top.sv */
`timescale 1ns/1ps

module dadda_mult_top #(
    parameter int cpa_block_width = 4   // 1 to 14
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  mul_types_pkg::operand_t  a,
    input  mul_types_pkg::operand_t  b,
    output logic                     out_valid,
    output mul_types_pkg::product_t  product
);
    import mul_types_pkg::*;

    logic      pp_valid;
    pp_array_t pp_array;

    cpa_if rows ();

    pp_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .pp_valid (pp_valid),
        .pp_array (pp_array)
    );

    dadda_reduce u_reduce (
        .clk      (clk),
        .rst_n    (rst_n),
        .pp_valid (pp_valid),
        .pp_array (pp_array),
        .rows     (rows.src)
    );

    cpa_result #(
        .cpa_block_width (cpa_block_width)
    ) u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .rows      (rows.dst),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

/* verilog/cpa_result.sv */
`timescale 1ns/1ps

module cpa_result #(
    parameter int cpa_block_width = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    cpa_if.dst                       rows,
    output logic                     out_valid,
    output mul_types_pkg::product_t  product
);
    import mul_types_pkg::*;
    import cla_pkg::*;

    // A width of 14 gives one long lookahead adder
    localparam int num_blocks = (ROW_WIDTH + cpa_block_width - 1) / cpa_block_width;

    logic [num_blocks:0] carry;
    cpa_row_t            sum;

    assign carry[0] = 1'b0;

    for (genvar k = 0; k < num_blocks; k++) begin : g_blk
        localparam int blk_lo = k * cpa_block_width;
        // Last block takes what is left of the row
        localparam int blk_w  = (ROW_WIDTH - blk_lo < cpa_block_width) ?
                                (ROW_WIDTH - blk_lo) : cpa_block_width;

        cla_res_t res;

        assign res = cla_block(cla_vec_t'(rows.row_a[blk_lo +: blk_w]),
                               cla_vec_t'(rows.row_b[blk_lo +: blk_w]),
                               carry[k], blk_w);
        assign sum[blk_lo +: blk_w] = res[blk_w-1:0];
        assign carry[k+1]           = res[CLA_VEC_WIDTH];   // Chains into the next block
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rows.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rows.valid) begin
            product <= {carry[num_blocks], sum, rows.lsb};
        end
    end

endmodule

/* verilog/dadda_reduce.sv */
`timescale 1ns/1ps

module dadda_reduce (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pp_valid,
    input  mul_types_pkg::pp_array_t  pp_array,
    cpa_if.src                        rows
);
    import mul_types_pkg::*;
    import cla_pkg::*;

    localparam int num_blk = 11;

    // Block 6 is the only two-bit block
    localparam int blk_width [1:num_blk] = '{4, 4, 4, 4, 4, 2, 4, 4, 4, 4, 4};

    cla_gp_t  blk_x [1:num_blk];
    cla_gp_t  blk_y [1:num_blk];
    logic     blk_cin [1:num_blk];
    cla_gp_t  s [1:num_blk];    // Sum bits of each block
    logic     c [1:num_blk];    // Carry out of each block
    cpa_row_t row_a_d;
    cpa_row_t row_b_d;

    // First level works on plain partial-product diagonals
    assign blk_x[1]   = pp_array[2][7:4];
    assign blk_y[1]   = pp_array[3][6:3];
    assign blk_cin[1] = 1'b0;

    assign blk_x[2]   = pp_array[4][4:1];
    assign blk_y[2]   = pp_array[5][3:0];
    assign blk_cin[2] = 1'b0;

    assign blk_x[3]   = pp_array[6][4:1];
    assign blk_y[3]   = pp_array[7][3:0];
    assign blk_cin[3] = 1'b0;

    assign blk_x[4]   = pp_array[0][6:3];
    assign blk_y[4]   = pp_array[1][5:2];
    assign blk_cin[4] = 1'b0;

    assign blk_x[5]   = {pp_array[3][7], pp_array[4][5], pp_array[1][7], pp_array[0][7]};
    assign blk_y[5]   = {pp_array[4][6], pp_array[5][4], s[1][2], pp_array[1][6]};
    assign blk_cin[5] = s[3][0];    // Spare bit of block 3 enters as carry

    assign blk_x[6]   = {2'b00, pp_array[5][7], pp_array[4][7]};
    assign blk_y[6]   = {2'b00, pp_array[6][6], pp_array[5][6]};
    assign blk_cin[6] = c[3];

    // Second level mixes sums and carries of the first
    assign blk_x[7]   = {s[1][1], pp_array[6][0], pp_array[2][3], pp_array[2][2]};
    assign blk_y[7]   = {s[2][2], s[1][0], pp_array[3][2], pp_array[3][1]};
    assign blk_cin[7] = 1'b0;

    assign blk_x[8]   = {pp_array[6][5], pp_array[5][5], s[1][3], s[2][3]};
    assign blk_y[8]   = {pp_array[7][4], c[1], c[2], s[3][1]};
    assign blk_cin[8] = 1'b0;

    assign blk_x[9]   = {s[2][0], pp_array[4][0], pp_array[2][1], pp_array[0][2]};
    assign blk_y[9]   = {s[4][2], s[4][1], pp_array[3][0], pp_array[1][1]};
    assign blk_cin[9] = 1'b0;

    assign blk_x[10]   = {s[3][2], s[5][1], c[4], s[2][1]};
    assign blk_y[10]   = {s[5][2], c[7], s[5][0], s[4][3]};
    assign blk_cin[10] = s[7][2];

    assign blk_x[11]   = {pp_array[6][7], pp_array[7][5], c[5], s[3][3]};
    assign blk_y[11]   = {pp_array[7][6], s[6][1], s[6][0], s[5][3]};
    assign blk_cin[11] = s[8][2];

    for (genvar k = 1; k <= num_blk; k++) begin : g_cla
        cla_res_t res;

        assign res  = cla_block(cla_vec_t'(blk_x[k]), cla_vec_t'(blk_y[k]), blk_cin[k],
                                blk_width[k]);
        assign s[k] = res[CLA_MAX_WIDTH-1:0];
        assign c[k] = res[CLA_VEC_WIDTH];
    end

    // Two rows for product bits 1 to 14, bit 1 at the right
    assign row_a_d = {pp_array[7][7], c[6], c[8], s[8][3], c[10], s[8][1], s[8][0],
                      s[7][3], c[9], s[7][1], s[7][0], s[4][0], pp_array[2][0],
                      pp_array[0][1]};
    assign row_b_d = {c[11], s[11], s[10], s[9], pp_array[1][0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rows.valid <= 1'b0;
        end else begin
            rows.valid <= pp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pp_valid) begin
            rows.row_a <= row_a_d;
            rows.row_b <= row_b_d;
            rows.lsb   <= pp_array[0][0];
        end
    end

endmodule

/* verilog/pp_decode.sv */
`timescale 1ns/1ps

module pp_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  mul_types_pkg::operand_t   a,
    input  mul_types_pkg::operand_t   b,
    output logic                      pp_valid,
    output mul_types_pkg::pp_array_t  pp_array
);
    import mul_types_pkg::*;

    pp_array_t pp_next;

    // Row i is the multiplicand a gated by multiplier bit b[i]
    always_comb begin
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            pp_next[i] = a & {OPERAND_WIDTH{b[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pp_array <= pp_next;    // Held while idle
        end
    end

endmodule

/* verilog/cpa_if.sv */
`timescale 1ns/1ps

interface cpa_if;
    import mul_types_pkg::*;

    logic     valid;
    cpa_row_t row_a;    // Product bits 1 to 14
    cpa_row_t row_b;
    logic     lsb;      // Product bit 0, no addition needed

    modport src (
        output valid,
        output row_a,
        output row_b,
        output lsb
    );

    modport dst (
        input valid,
        input row_a,
        input row_b,
        input lsb
    );

endinterface

/* verilog/cla_pkg.sv */
package cla_pkg;

    localparam int CLA_MAX_WIDTH = 4;   // Widest block in the reduction tree

    // The final adder may run all 14 row bits as one block
    localparam int CLA_VEC_WIDTH = mul_types_pkg::ROW_WIDTH;

    typedef logic [CLA_MAX_WIDTH-1:0] cla_gp_t;
    typedef logic [CLA_VEC_WIDTH-1:0] cla_vec_t;
    typedef logic [CLA_VEC_WIDTH:0] cla_res_t;   // Carry out on top, sum bits below

    // Lookahead block of the given width, sum bits above width read as zero
    function automatic cla_res_t cla_block(
        input cla_vec_t x,
        input cla_vec_t y,
        input logic     cin,
        input int       width
    );
        cla_vec_t               g;
        cla_vec_t               p;
        logic [CLA_VEC_WIDTH:0] carry;
        cla_res_t               res;
        g        = x & y;
        p        = x ^ y;
        carry    = '0;
        carry[0] = cin;
        res      = '0;
        for (int i = 0; i < CLA_VEC_WIDTH; i++) begin
            if (i < width) begin
                carry[i+1] = g[i] | (p[i] & carry[i]);
                res[i]     = p[i] ^ carry[i];
            end
        end
        res[CLA_VEC_WIDTH] = carry[width];
        return res;
    endfunction

endpackage

/* verilog/mul_types_pkg.sv */
package mul_types_pkg;

    localparam int OPERAND_WIDTH = 8;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // Bit 0 bypasses the adder and the carry out becomes the top bit
    localparam int ROW_WIDTH = PRODUCT_WIDTH - 2;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // Multiplicand gated by one multiplier bit
    typedef logic [OPERAND_WIDTH-1:0] pp_row_t;

    // Indexed by multiplier bit, then by multiplicand bit
    typedef pp_row_t [OPERAND_WIDTH-1:0] pp_array_t;

    // Product bits 1 to 14
    typedef logic [ROW_WIDTH-1:0] cpa_row_t;

endpackage
